// File: rtl/bios_loader_pkg.sv
package bios_loader_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus and stream widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int MEM_ADDR_WIDTH   = 20;
    localparam int IOCTL_ADDR_WIDTH = 25;
    localparam int INDEX_WIDTH      = 8;
    localparam int DATA_WIDTH       = 8;
    localparam int TIMER_WIDTH      = 6;

    // size of the address window inside each image
    localparam int SYSTEM_BIOS_ADDR_BITS = 16;
    localparam int XTIDE_ADDR_BITS       = 14;

    ////////////////////////////////////////////////////////////////////////////
    // write timing, in clk_chipset cycles
    ////////////////////////////////////////////////////////////////////////////

    // low time of the memory write strobe
    localparam logic [TIMER_WIDTH-1:0] WRITE_PULSE_CYCLES = 6'd20;
    // timer count where recovery ends and the next byte may come
    localparam logic [TIMER_WIDTH-1:0] WRITE_CYCLE_CYCLES = 6'd40;

    ////////////////////////////////////////////////////////////////////////////
    // image selection and memory map
    ////////////////////////////////////////////////////////////////////////////

    // indexes below the tandy one select the pc xt image
    localparam logic [INDEX_WIDTH-1:0] INDEX_TANDY = 8'd2;
    localparam logic [INDEX_WIDTH-1:0] INDEX_XTIDE = 8'd3;

    // top 64 KiB of the 1 MiB space
    localparam logic [MEM_ADDR_WIDTH-1:0] SYSTEM_BIOS_BASE = 20'hF0000;
    // 16 KiB option rom window
    localparam logic [MEM_ADDR_WIDTH-1:0] XTIDE_BASE = 20'hEC000;

    // values the bus sees between writes
    localparam logic [MEM_ADDR_WIDTH-1:0] IDLE_ADDRESS = 20'hFFFFF;
    localparam logic [DATA_WIDTH-1:0]     IDLE_DATA    = 8'hFF;

    // loader sequence
    typedef enum logic [1:0]
    {
        IDLE        = 2'd0,
        WAIT_BYTE   = 2'd1,
        WRITE_PULSE = 2'd2,
        RECOVER     = 2'd3
    } load_state_t;

endpackage

// File: rtl/bios_load_fsm.sv
module bios_load_fsm
(
    input  logic clk_chipset,
    input  logic reset,
    input  logic ioctl_download,
    input  logic ioctl_wr,
    input  logic bus_grant,
    input  logic sdram_ready,
    input  logic load_valid,
    input  logic pulse_done,
    input  logic cycle_done,
    output logic capture,
    output logic timer_clear,
    output logic write_active,
    output logic ioctl_wait,
    output logic mem_access_request,
    output logic bios_protect_flag
);

    bios_loader_pkg::load_state_t load_state;

    // a byte is taken only when it maps into one of the images
    assign capture = (load_state == bios_loader_pkg::WAIT_BYTE) && ioctl_download
                     && ioctl_wr && load_valid;

    // timer restarts in every state outside the write cycle
    assign timer_clear = (load_state == bios_loader_pkg::IDLE)
                         || (load_state == bios_loader_pkg::WAIT_BYTE);

    assign write_active = (load_state == bios_loader_pkg::WRITE_PULSE);

    ////////////////////////////////////////////////////////////////////////////
    // state and handshake registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
        begin
            load_state         <= bios_loader_pkg::IDLE;
            ioctl_wait         <= 1'b1;
            mem_access_request <= 1'b0;
            bios_protect_flag  <= 1'b1;
        end
        else
        begin
            case (load_state)
                bios_loader_pkg::IDLE:
                begin
                    bios_protect_flag <= 1'b1;
                    if (~sdram_ready)
                    begin
                        // memory not up yet, hold the downloader off
                        ioctl_wait         <= 1'b1;
                        mem_access_request <= 1'b0;
                    end
                    else if (~ioctl_download)
                    begin
                        ioctl_wait         <= 1'b0;
                        mem_access_request <= 1'b0;
                    end
                    else
                    begin
                        mem_access_request <= 1'b1;
                        if (bus_grant)
                        begin
                            bios_protect_flag <= 1'b0;
                            ioctl_wait        <= 1'b0;
                            load_state        <= bios_loader_pkg::WAIT_BYTE;
                        end
                        else
                            ioctl_wait <= 1'b1;
                    end
                end
                bios_loader_pkg::WAIT_BYTE:
                begin
                    if (~ioctl_download)
                    begin
                        // image complete, give the bus back
                        bios_protect_flag  <= 1'b1;
                        mem_access_request <= 1'b0;
                        ioctl_wait         <= 1'b0;
                        load_state         <= bios_loader_pkg::IDLE;
                    end
                    else if (capture)
                    begin
                        ioctl_wait <= 1'b1;
                        load_state <= bios_loader_pkg::WRITE_PULSE;
                    end
                    else
                        ioctl_wait <= 1'b0;
                end
                bios_loader_pkg::WRITE_PULSE:
                begin
                    ioctl_wait <= 1'b1;
                    if (pulse_done)
                        load_state <= bios_loader_pkg::RECOVER;
                end
                bios_loader_pkg::RECOVER:
                begin
                    if (cycle_done)
                    begin
                        ioctl_wait <= 1'b0;
                        load_state <= bios_loader_pkg::WAIT_BYTE;
                    end
                    else
                        ioctl_wait <= 1'b1;
                end
                default:
                    load_state <= bios_loader_pkg::IDLE;
            endcase
        end
    end

endmodule

// File: rtl/bios_write_timer.sv
module bios_write_timer
(
    input  logic clk_chipset,
    input  logic reset,
    input  logic timer_clear,
    output logic pulse_done,
    output logic cycle_done
);

    logic [bios_loader_pkg::TIMER_WIDTH-1:0] count;

    // the capture cycle counts as the first tick of the write
    localparam logic [bios_loader_pkg::TIMER_WIDTH-1:0] START_COUNT =
        {{(bios_loader_pkg::TIMER_WIDTH-1){1'b0}}, 1'b1};

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (timer_clear)
            count <= START_COUNT;
        else if (count != bios_loader_pkg::WRITE_CYCLE_CYCLES)
            count <= count + 1'b1;
    end

    // last cycle of the strobe
    assign pulse_done = (count == bios_loader_pkg::WRITE_PULSE_CYCLES);

    // last cycle of recovery, counter parks here
    assign cycle_done = (count == bios_loader_pkg::WRITE_CYCLE_CYCLES);

endmodule

// File: rtl/bios_image_decoder.sv
module bios_image_decoder
(
    input  logic                                         clk_chipset,
    input  logic                                         reset,
    input  logic [bios_loader_pkg::INDEX_WIDTH-1:0]      ioctl_index,
    input  logic [bios_loader_pkg::IOCTL_ADDR_WIDTH-1:0] ioctl_addr,
    input  logic [bios_loader_pkg::DATA_WIDTH-1:0]       ioctl_data,
    input  logic                                         capture,
    input  logic                                         write_active,
    output logic                                         load_valid,
    output logic [bios_loader_pkg::MEM_ADDR_WIDTH-1:0]   mem_address,
    output logic [bios_loader_pkg::DATA_WIDTH-1:0]       mem_data,
    output logic                                         tandy_bios_write
);

    localparam int SYS_BITS   = bios_loader_pkg::SYSTEM_BIOS_ADDR_BITS;
    localparam int XTIDE_BITS = bios_loader_pkg::XTIDE_ADDR_BITS;
    localparam int MEM_W      = bios_loader_pkg::MEM_ADDR_WIDTH;
    localparam int IOCTL_W    = bios_loader_pkg::IOCTL_ADDR_WIDTH;

    logic                                       in_system_window;
    logic                                       select_pcxt;
    logic                                       select_tandy;
    logic                                       select_xtide;
    logic [MEM_W-1:0]                           system_offset;
    logic [MEM_W-1:0]                           xtide_offset;
    logic [MEM_W-1:0]                           mapped_address;
    logic [MEM_W-1:0]                           address_hold;
    logic [bios_loader_pkg::DATA_WIDTH-1:0]     data_hold;
    logic                                       tandy_hold;

    ////////////////////////////////////////////////////////////////////////////
    // image select
    ////////////////////////////////////////////////////////////////////////////

    // system images must fit in 64 KiB
    assign in_system_window = (ioctl_addr[IOCTL_W-1:SYS_BITS] == '0);

    assign select_pcxt  = (ioctl_index < bios_loader_pkg::INDEX_TANDY) && in_system_window;
    assign select_tandy = (ioctl_index == bios_loader_pkg::INDEX_TANDY) && in_system_window;
    // option rom wraps inside its window
    assign select_xtide = (ioctl_index == bios_loader_pkg::INDEX_XTIDE);

    assign load_valid = select_pcxt | select_tandy | select_xtide;

    // base addresses have zero low bits, so the offset is or'ed in
    assign system_offset = {{(MEM_W-SYS_BITS){1'b0}}, ioctl_addr[SYS_BITS-1:0]};
    assign xtide_offset  = {{(MEM_W-XTIDE_BITS){1'b0}}, ioctl_addr[XTIDE_BITS-1:0]};

    assign mapped_address = select_xtide ? (bios_loader_pkg::XTIDE_BASE | xtide_offset)
                                         : (bios_loader_pkg::SYSTEM_BIOS_BASE | system_offset);

    ////////////////////////////////////////////////////////////////////////////
    // captured write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_chipset)
    begin
        if (capture)
        begin
            address_hold <= mapped_address;
            data_hold    <= ioctl_data;
        end
    end

    always_ff @(posedge clk_chipset, posedge reset)
    begin
        if (reset)
            tandy_hold <= 1'b0;
        else if (capture)
            tandy_hold <= select_tandy;
    end

    // bus shows idle values outside the strobe
    assign mem_address      = write_active ? address_hold : bios_loader_pkg::IDLE_ADDRESS;
    assign mem_data         = write_active ? data_hold : bios_loader_pkg::IDLE_DATA;
    assign tandy_bios_write = write_active & tandy_hold;

endmodule

// File: rtl/bios_loader_top.sv
module bios_loader_top
(
    input  logic                                         clk_chipset,
    input  logic                                         reset,
    input  logic                                         ioctl_download,
    input  logic [bios_loader_pkg::INDEX_WIDTH-1:0]      ioctl_index,
    input  logic [bios_loader_pkg::IOCTL_ADDR_WIDTH-1:0] ioctl_addr,
    input  logic [bios_loader_pkg::DATA_WIDTH-1:0]       ioctl_data,
    input  logic                                         ioctl_wr,
    input  logic                                         bus_grant,
    input  logic                                         sdram_ready,
    output logic                                         ioctl_wait,
    output logic                                         mem_access_request,
    output logic [bios_loader_pkg::MEM_ADDR_WIDTH-1:0]   mem_address,
    output logic [bios_loader_pkg::DATA_WIDTH-1:0]       mem_data,
    output logic                                         mem_write_n,
    output logic                                         bios_protect_flag,
    output logic                                         tandy_bios_write
);

    logic load_valid;
    logic capture;
    logic timer_clear;
    logic write_active;
    logic pulse_done;
    logic cycle_done;

    // strobe is low for the whole pulse state
    assign mem_write_n = ~write_active;

    bios_load_fsm u_bios_load_fsm
    (
        .clk_chipset        (clk_chipset),
        .reset              (reset),
        .ioctl_download     (ioctl_download),
        .ioctl_wr           (ioctl_wr),
        .bus_grant          (bus_grant),
        .sdram_ready        (sdram_ready),
        .load_valid         (load_valid),
        .pulse_done         (pulse_done),
        .cycle_done         (cycle_done),
        .capture            (capture),
        .timer_clear        (timer_clear),
        .write_active       (write_active),
        .ioctl_wait         (ioctl_wait),
        .mem_access_request (mem_access_request),
        .bios_protect_flag  (bios_protect_flag)
    );

    bios_write_timer u_bios_write_timer
    (
        .clk_chipset (clk_chipset),
        .reset       (reset),
        .timer_clear (timer_clear),
        .pulse_done  (pulse_done),
        .cycle_done  (cycle_done)
    );

    bios_image_decoder u_bios_image_decoder
    (
        .clk_chipset      (clk_chipset),
        .reset            (reset),
        .ioctl_index      (ioctl_index),
        .ioctl_addr       (ioctl_addr),
        .ioctl_data       (ioctl_data),
        .capture          (capture),
        .write_active     (write_active),
        .load_valid       (load_valid),
        .mem_address      (mem_address),
        .mem_data         (mem_data),
        .tandy_bios_write (tandy_bios_write)
    );

endmodule

// File: dv/bios_loader_assertions.sv
module bios_loader_assertions
(
    input logic                                       clk_chipset,
    input logic                                       reset,
    input logic                                       ioctl_wr,
    input logic                                       ioctl_wait,
    input logic                                       mem_write_n,
    input logic [bios_loader_pkg::MEM_ADDR_WIDTH-1:0] mem_address,
    input logic                                       bios_protect_flag
);

    timeunit 1ns;
    timeprecision 100ps;

    // strobe only while the downloader is held off and the rom is open
    write_holds_off : assert property (
        @(posedge clk_chipset) disable iff (reset)
        !mem_write_n |-> (ioctl_wait && !bios_protect_flag)
    )
    else
        $error("memory write with ioctl_wait low or bios write protected");

    // bus parked between writes
    idle_address : assert property (
        @(posedge clk_chipset) disable iff (reset)
        mem_write_n |-> (mem_address == bios_loader_pkg::IDLE_ADDRESS)
    )
    else
        $error("mem_address not parked while mem_write_n is high");

    // a byte offered against back-pressure must be dropped
    no_write_on_wait : assert property (
        @(posedge clk_chipset) disable iff (reset)
        (ioctl_wr && ioctl_wait) |=> !$fell(mem_write_n)
    )
    else
        $error("write started from a byte offered while ioctl_wait was high");

endmodule

// File: dv/tb_bios_loader.sv
module tb_bios_loader;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 200;
    localparam int PULSE_LIMIT = 64;

    typedef struct packed
    {
        logic        written;
        logic        tandy;
        logic [19:0] address;
    } write_ref_t;

    typedef struct packed
    {
        logic        tandy;
        logic [19:0] address;
        logic [7:0]  data;
    } exp_write_t;

    logic        clk_chipset;
    logic        reset;
    logic        ioctl_download;
    logic [7:0]  ioctl_index;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        bus_grant;
    logic        sdram_ready;
    logic        ioctl_wait;
    logic        mem_access_request;
    logic [19:0] mem_address;
    logic [7:0]  mem_data;
    logic        mem_write_n;
    logic        bios_protect_flag;
    logic        tandy_bios_write;

    integer     seed = 94153;
    int         errors = 0;
    int         writes_checked = 0;
    exp_write_t expected_q[$];

    bios_loader_top DUT
    (
        .clk_chipset        (clk_chipset),
        .reset              (reset),
        .ioctl_download     (ioctl_download),
        .ioctl_index        (ioctl_index),
        .ioctl_addr         (ioctl_addr),
        .ioctl_data         (ioctl_data),
        .ioctl_wr           (ioctl_wr),
        .bus_grant          (bus_grant),
        .sdram_ready        (sdram_ready),
        .ioctl_wait         (ioctl_wait),
        .mem_access_request (mem_access_request),
        .mem_address        (mem_address),
        .mem_data           (mem_data),
        .mem_write_n        (mem_write_n),
        .bios_protect_flag  (bios_protect_flag),
        .tandy_bios_write   (tandy_bios_write)
    );

    bind bios_loader_top bios_loader_assertions u_assertions
    (
        .clk_chipset       (clk_chipset),
        .reset             (reset),
        .ioctl_wr          (ioctl_wr),
        .ioctl_wait        (ioctl_wait),
        .mem_write_n       (mem_write_n),
        .mem_address       (mem_address),
        .bios_protect_flag (bios_protect_flag)
    );

    always #10 clk_chipset = ~clk_chipset;

    ////////////////////////////////////////////////////////////////////////////
    // expected behaviour and checks
    ////////////////////////////////////////////////////////////////////////////

    // indexes 0 to 2 map into the top 64 KiB and 3 into the option rom window
    function automatic write_ref_t expected_write(input logic [7:0] index,
                                                  input logic [24:0] addr);
        write_ref_t r;
        r.written = 1'b0;
        r.tandy   = 1'b0;
        r.address = 20'hFFFFF;
        if (index <= 8'd2 && addr < 25'h10000)
        begin
            r.written = 1'b1;
            r.tandy   = (index == 8'd2);
            r.address = 20'hF0000 + addr[19:0];
        end
        else if (index == 8'd3)
        begin
            r.written = 1'b1;
            r.address = 20'hEC000 + {6'd0, addr[13:0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic end_run();
        $display("writes checked: %0d, errors: %0d", writes_checked, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at t=%0t: %s", $time, what);
        end_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // download stream driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_ioctl_wait_low();
        int cycles;
        cycles = 0;
        while (ioctl_wait !== 1'b0 && cycles < WAIT_LIMIT)
        begin
            @(posedge clk_chipset);
            #2;
            cycles++;
        end
        if (ioctl_wait !== 1'b0)
            report_timeout("ioctl_wait never went low");
    endtask

    task automatic wait_protect_low();
        int cycles;
        cycles = 0;
        while (bios_protect_flag !== 1'b0 && cycles < WAIT_LIMIT)
        begin
            @(posedge clk_chipset);
            #2;
            cycles++;
        end
        if (bios_protect_flag !== 1'b0)
            report_timeout("bios_protect_flag never dropped for the download");
    endtask

    task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
        write_ref_t ref_w;
        exp_write_t exp_w;
        ref_w = expected_write(ioctl_index, addr);
        wait_ioctl_wait_low();
        // queued before the strobe can fall
        if (ref_w.written)
        begin
            exp_w.tandy   = ref_w.tandy;
            exp_w.address = ref_w.address;
            exp_w.data    = data;
            expected_q.push_back(exp_w);
        end
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(posedge clk_chipset);
        #2;
        ioctl_wr = 1'b0;
        if (!ref_w.written)
        begin
            // skipped byte gets no back-pressure and no strobe
            check_value("ioctl_wait", 32'(ioctl_wait), 32'd0);
            check_value("mem_write_n", 32'(mem_write_n), 32'd1);
        end
    endtask

    task automatic load_image(input logic [7:0] index, input int count,
                              input logic [24:0] addr_mask, input logic [24:0] addr_set);
        logic [31:0] rnd;
        logic [24:0] addr;
        ioctl_index    = index;
        ioctl_download = 1'b1;
        bus_grant      = 1'b1;
        wait_protect_low();
        check_value("mem_access_request", 32'(mem_access_request), 32'd1);
        for (int i = 0; i < count; i++)
        begin
            rnd  = $random(seed);
            addr = (rnd[24:0] & addr_mask) | addr_set;
            rnd  = $random(seed);
            send_byte(addr, rnd[7:0]);
        end
        wait_ioctl_wait_low();
        ioctl_download = 1'b0;
        @(posedge clk_chipset);
        #2;
        check_value("bios_protect_flag", 32'(bios_protect_flag), 32'd1);
        check_value("mem_access_request", 32'(mem_access_request), 32'd0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // write checker
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        exp_write_t exp_w;
        int         width;
        forever
        begin
            @(negedge mem_write_n);
            #1;
            assert (expected_q.size() != 0)
            else
            begin
                errors++;
                $display("unexpected write to %h at t=%0t with no byte pending",
                         mem_address, $time);
            end
            if (expected_q.size() != 0)
            begin
                exp_w = expected_q.pop_front();
                check_value("mem_address", 32'(mem_address), 32'(exp_w.address));
                check_value("mem_data", 32'(mem_data), 32'(exp_w.data));
                check_value("tandy_bios_write", 32'(tandy_bios_write), 32'(exp_w.tandy));
                writes_checked++;
            end
            width = 0;
            while (mem_write_n === 1'b0 && width < PULSE_LIMIT)
            begin
                @(posedge clk_chipset);
                #1;
                width++;
            end
            check_value("mem_write_n low width", width, 32'd20);
            // tandy mark drops with the strobe
            check_value("tandy_bios_write", 32'(tandy_bios_write), 32'd0);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        clk_chipset    = 1'b0;
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_index    = 8'd0;
        ioctl_addr     = '0;
        ioctl_data     = 8'd0;
        ioctl_wr       = 1'b0;
        bus_grant      = 1'b0;
        sdram_ready    = 1'b0;
        repeat (8) @(posedge clk_chipset);
        #2;
        reset = 1'b0;
        @(posedge clk_chipset);
        #2;
        check_value("ioctl_wait", 32'(ioctl_wait), 32'd1);
        check_value("mem_access_request", 32'(mem_access_request), 32'd0);
        check_value("mem_address", 32'(mem_address), 32'hFFFFF);
        check_value("mem_data", 32'(mem_data), 32'hFF);
        check_value("mem_write_n", 32'(mem_write_n), 32'd1);
        check_value("bios_protect_flag", 32'(bios_protect_flag), 32'd1);
        check_value("tandy_bios_write", 32'(tandy_bios_write), 32'd0);
        sdram_ready = 1'b1;
        wait_ioctl_wait_low();

        // pc xt on both of its indexes
        load_image(8'd0, 12, 25'h00FFFF, 25'h0);
        load_image(8'd1, 4, 25'h00FFFF, 25'h0);
        // xt-ide with most addresses above 16 KiB
        load_image(8'd3, 12, 25'h01FFFF, 25'h0);
        load_image(8'd2, 8, 25'h00FFFF, 25'h0);
        // unknown image and then a system image out of range
        load_image(8'd5, 4, 25'h00FFFF, 25'h0);
        load_image(8'd0, 4, 25'h1FFFFFF, 25'h010000);

        assert (expected_q.size() == 0)
        else
        begin
            errors++;
            $display("%0d expected writes never reached the memory bus", expected_q.size());
        end
        end_run();
    end

endmodule

// File: verilog.f
rtl/bios_loader_pkg.sv
rtl/bios_load_fsm.sv
rtl/bios_write_timer.sv
rtl/bios_image_decoder.sv
rtl/bios_loader_top.sv
dv/bios_loader_assertions.sv
dv/tb_bios_loader.sv

// File: Makefile
TOP := tb_bios_loader

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qF "*** TEST PASSED ***" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
